// ==== sources.f ====
+incdir+verif
source/uart_cfg_pkg.sv
source/uart_msg_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_ctrl.sv
source/uart_top.sv
verif/uart_tb.sv

// ==== verif/uart_tb_ref.svh ====
// testbench helpers; they use lfsr, err_cnt and check_cnt declared in the including module
function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    // taps 32, 22, 2, 1
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one LFSR step per bit taken
function automatic uart_cfg_pkg::data_t rand_byte();
    uart_cfg_pkg::data_t b;
    int i;
    for (i = 0; i < uart_cfg_pkg::data_bits; i++) begin
        lfsr = next_lfsr(lfsr);
        b[i] = lfsr[0];
    end
    return b;
endfunction

// line order: start 0, data LSB first, stop 1
function automatic logic [uart_cfg_pkg::data_bits+1:0] ref_frame(input uart_cfg_pkg::data_t d);
    return {1'b1, d, 1'b0};
endfunction

function automatic uart_msg_pkg::rx_msg_t expected_msg(input uart_cfg_pkg::data_t d,
                                                      input logic stop_bit,
                                                      input logic pend_ovr);
    uart_msg_pkg::rx_msg_t m;
    m.data      = d;
    m.frame_err = ~stop_bit;
    m.overrun   = pend_ovr;
    return m;
endfunction

task automatic compare_msg(input uart_msg_pkg::rx_msg_t got, input uart_msg_pkg::rx_msg_t exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("[FAIL] t=%0t rx_msg data %02h ferr %b ovr %b, expected data %02h ferr %b ovr %b",
                 $time, got.data, got.frame_err, got.overrun,
                 exp.data, exp.frame_err, exp.overrun);
    end
endtask

task automatic compare_bit(input string what, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("[FAIL] t=%0t %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// ==== verif/uart_tb.sv ====
`timescale 1ns/1ps
// UART link testbench; checks loopback, framing error, start glitch and overrun at 40 ns clock
module uart_tb;

    localparam int clk_period  = 40;
    localparam int reset_cycles = 5;
    localparam int frame_clks  = (uart_cfg_pkg::data_bits + 2) * uart_cfg_pkg::clks_per_bit;
    // 20 loopback, 1 bad stop, glitch plus 1 frame, 3 overrun
    localparam int n_frames    = 26;
    localparam int max_cycles  = n_frames * frame_clks * 3 + reset_cycles;

    logic                  clk;
    logic                  rst_n;
    logic                  tx_req;
    uart_cfg_pkg::data_t   tx_data;
    logic                  tx_ack;
    logic                  rx_req;
    uart_msg_pkg::rx_msg_t rx_msg;
    logic                  rx_ack;
    logic                  rx_line;
    logic                  tx_line;

    logic                  loop_sel;
    logic                  bang_line;
    logic                  ack_hold;
    logic                  pend_ovr;
    logic [31:0]           lfsr;
    int                    err_cnt;
    int                    check_cnt;
    int                    cycle_cnt = 0;
    uart_msg_pkg::rx_msg_t exp_q[$];

    `include "uart_tb_ref.svh"

    assign rx_line = loop_sel ? tx_line : bang_line;

    uart_top uart_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_req  (tx_req),
        .tx_data (tx_data),
        .tx_ack  (tx_ack),
        .rx_req  (rx_req),
        .rx_msg  (rx_msg),
        .rx_ack  (rx_ack),
        .rx_line (rx_line),
        .tx_line (tx_line)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin : watchdog
        wait (cycle_cnt >= max_cycles);
        $display("timeout: test did not finish within %0d cycles", max_cycles);
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        $display("Simulation failed");
        $finish;
    end

    // takes each message the DUT offers and completes the handshake
    initial begin : check_rx
        uart_msg_pkg::rx_msg_t exp;
        forever begin
            @(negedge clk);
            if (rx_req && !rx_ack && !ack_hold) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("unexpected rx_req with no frame outstanding at time %0t", $time);
                end else begin
                    exp = exp_q.pop_front();
                    compare_msg(rx_msg, exp);
                end
                @(posedge clk);
                rx_ack <= 1'b1;
            end else if (rx_ack && !rx_req) begin
                @(posedge clk);
                rx_ack <= 1'b0;
            end
        end
    end

    task automatic expect_frame(input uart_cfg_pkg::data_t d, input logic stop_bit);
        exp_q.push_back(expected_msg(d, stop_bit, pend_ovr));
        pend_ovr = 1'b0;
    endtask

    task automatic send_byte(input uart_cfg_pkg::data_t d);
        logic [uart_cfg_pkg::data_bits+1:0] frame;
        int since;
        int i;
        frame = ref_frame(d);
        @(posedge clk);
        tx_data <= d;
        tx_req  <= 1'b1;
        @(negedge clk);
        while (tx_line) @(negedge clk);
        repeat (uart_cfg_pkg::half_bit) @(negedge clk);
        since = uart_cfg_pkg::half_bit;
        for (i = 0; i < uart_cfg_pkg::data_bits + 2; i++) begin
            compare_bit($sformatf("tx_line bit %0d of %02h", i, d), tx_line, frame[i]);
            compare_bit("tx_ack inside frame", tx_ack, 1'b0);
            if (i < uart_cfg_pkg::data_bits + 1) begin
                repeat (uart_cfg_pkg::clks_per_bit) @(negedge clk);
                since += uart_cfg_pkg::clks_per_bit;
            end
        end
        while (!tx_ack) begin
            @(negedge clk);
            since++;
        end
        compare_bit("tx_ack after full frame", since >= frame_clks, 1'b1);
        @(posedge clk);
        tx_req <= 1'b0;
        @(negedge clk);
        while (tx_ack) @(negedge clk);
    endtask

    task automatic bang_frame(input uart_cfg_pkg::data_t d, input logic stop_bit);
        logic [uart_cfg_pkg::data_bits+1:0] bits;
        int i;
        bits = {stop_bit, d, 1'b0};
        for (i = 0; i < uart_cfg_pkg::data_bits + 2; i++) begin
            @(posedge clk);
            bang_line <= bits[i];
            repeat (uart_cfg_pkg::clks_per_bit - 1) @(posedge clk);
        end
        @(posedge clk);
        bang_line <= 1'b1;
        repeat (uart_cfg_pkg::clks_per_bit) @(posedge clk);
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (exp_q.size() != 0 || rx_req || rx_ack) @(negedge clk);
    endtask

    initial begin : stimulus
        uart_cfg_pkg::data_t d;
        int n;
        rst_n     = 1'b0;
        tx_req    = 1'b0;
        tx_data   = '0;
        rx_ack    = 1'b0;
        bang_line = 1'b1;
        loop_sel  = 1'b1;
        ack_hold  = 1'b0;
        pend_ovr  = 1'b0;
        lfsr      = 32'h97b1_addd;
        err_cnt   = 0;
        check_cnt = 0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_bit("tx_line after reset", tx_line, 1'b1);
        compare_bit("tx_ack after reset", tx_ack, 1'b0);
        compare_bit("rx_req after reset", rx_req, 1'b0);

        // loopback with random data
        for (n = 0; n < 20; n++) begin
            d = rand_byte();
            expect_frame(d, 1'b1);
            send_byte(d);
        end
        wait_drained();

        // low stop bit
        @(posedge clk);
        loop_sel <= 1'b0;
        d = rand_byte();
        expect_frame(d, 1'b0);
        bang_frame(d, 1'b0);
        wait_drained();

        // start glitch shorter than half a bit
        @(posedge clk);
        ack_hold  <= 1'b1;
        bang_line <= 1'b0;
        repeat (3) @(posedge clk);
        bang_line <= 1'b1;
        // long enough for a false start to deliver a whole frame
        repeat (frame_clks + uart_cfg_pkg::clks_per_bit) @(posedge clk);
        @(negedge clk);
        compare_bit("rx_req after start glitch", rx_req, 1'b0);
        @(posedge clk);
        ack_hold <= 1'b0;
        d = rand_byte();
        expect_frame(d, 1'b1);
        bang_frame(d, 1'b1);
        wait_drained();

        // host stalls, second frame is dropped
        @(posedge clk);
        loop_sel <= 1'b1;
        ack_hold <= 1'b1;
        d = rand_byte();
        expect_frame(d, 1'b1);
        send_byte(d);
        d = rand_byte();
        pend_ovr = 1'b1;
        send_byte(d);
        @(posedge clk);
        ack_hold <= 1'b0;
        wait_drained();
        d = rand_byte();
        expect_frame(d, 1'b1);
        send_byte(d);
        wait_drained();

        repeat (uart_cfg_pkg::clks_per_bit) @(posedge clk);
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== source/uart_top.sv ====
`timescale 1ns/1ps
// UART link top; fixed 8N1 at clks_per_bit clocks per bit, host keeps tx_data stable under tx_req
module uart_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tx_req,
    input  uart_cfg_pkg::data_t   tx_data,
    output logic                  tx_ack,
    output logic                  rx_req,
    output uart_msg_pkg::rx_msg_t rx_msg,
    input  logic                  rx_ack,
    input  logic                  rx_line,
    output logic                  tx_line
);

    logic                    tx_start;
    logic                    tx_done;
    logic                    rx_valid;
    uart_msg_pkg::rx_frame_t rx_frame;

    uart_ctrl uart_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_req   (tx_req),
        .tx_ack   (tx_ack),
        .tx_start (tx_start),
        .tx_done  (tx_done),
        .rx_valid (rx_valid),
        .rx_frame (rx_frame),
        .rx_req   (rx_req),
        .rx_msg   (rx_msg),
        .rx_ack   (rx_ack)
    );

    // tx_data goes straight through, the host holds it for the whole request
    uart_tx uart_tx_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_line  (tx_line),
        .tx_done  (tx_done)
    );

    uart_rx uart_rx_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_line  (rx_line),
        .rx_frame (rx_frame),
        .rx_valid (rx_valid)
    );

endmodule

// ==== source/uart_ctrl.sv ====
`timescale 1ns/1ps
// host handshakes for the UART; holds a single receive message, later frames only set overrun
module uart_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tx_req,
    output logic                    tx_ack,
    output logic                    tx_start,
    input  logic                    tx_done,
    input  logic                    rx_valid,
    input  uart_msg_pkg::rx_frame_t rx_frame,
    output logic                    rx_req,
    output uart_msg_pkg::rx_msg_t   rx_msg,
    input  logic                    rx_ack
);

    uart_msg_pkg::hs_state_e tx_st;
    uart_msg_pkg::hs_state_e rx_st;
    logic                    overrun_q;
    logic                    rx_load;

    assign tx_ack  = (tx_st == uart_msg_pkg::hs_ack_high);
    assign rx_req  = (rx_st == uart_msg_pkg::hs_busy);

    // a frame is kept only when nothing is held
    assign rx_load = rx_valid && (rx_st == uart_msg_pkg::hs_idle);

    // transmit side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_st    <= uart_msg_pkg::hs_idle;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (tx_st)
                uart_msg_pkg::hs_idle: begin
                    if (tx_req) begin
                        tx_start <= 1'b1;
                        tx_st    <= uart_msg_pkg::hs_busy;
                    end
                end

                uart_msg_pkg::hs_busy: begin
                    // stop bit has fully left the line
                    if (tx_done) begin
                        tx_st <= uart_msg_pkg::hs_ack_high;
                    end
                end

                uart_msg_pkg::hs_ack_high: begin
                    if (!tx_req) begin
                        tx_st <= uart_msg_pkg::hs_wait_low;
                    end
                end

                uart_msg_pkg::hs_wait_low: begin
                    // ack low for one cycle before a new request is taken
                    tx_st <= uart_msg_pkg::hs_idle;
                end

                default: begin
                    tx_st <= uart_msg_pkg::hs_idle;
                end
            endcase
        end
    end

    // receive side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_st     <= uart_msg_pkg::hs_idle;
            overrun_q <= 1'b0;
        end else begin
            if (rx_load) begin
                overrun_q <= 1'b0;
            end else if (rx_valid) begin
                // dropped frame, reported with the next delivery
                overrun_q <= 1'b1;
            end

            case (rx_st)
                uart_msg_pkg::hs_idle: begin
                    if (rx_valid) begin
                        rx_st <= uart_msg_pkg::hs_busy;
                    end
                end

                uart_msg_pkg::hs_busy: begin
                    if (rx_ack) begin
                        rx_st <= uart_msg_pkg::hs_ack_high;
                    end
                end

                uart_msg_pkg::hs_ack_high: begin
                    if (!rx_ack) begin
                        rx_st <= uart_msg_pkg::hs_idle;
                    end
                end

                default: begin
                    rx_st <= uart_msg_pkg::hs_idle;
                end
            endcase
        end
    end

    // held message, stable while rx_req is high
    always_ff @(posedge clk) begin
        if (rx_load) begin
            rx_msg.data      <= rx_frame.data;
            rx_msg.frame_err <= rx_frame.frame_err;
            rx_msg.overrun   <= overrun_q;
        end
    end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps
// 8N1 transmitter; tx_start is only honoured while idle and tx_data is taken on that cycle
module uart_tx (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tx_start,
    input  uart_cfg_pkg::data_t tx_data,
    output logic                tx_line,
    output logic                tx_done
);

    uart_msg_pkg::tx_state_e             state;
    logic [uart_cfg_pkg::cnt_w-1:0]      baud_cnt;
    logic [uart_cfg_pkg::bit_cnt_w-1:0]  bit_cnt;
    uart_cfg_pkg::data_t                 shift_reg;
    logic                                bit_end;
    logic                                load;

    assign bit_end = (baud_cnt == uart_cfg_pkg::clks_per_bit - 1);
    assign load    = (state == uart_msg_pkg::tx_idle) && tx_start;

    // last cycle of the stop bit
    assign tx_done = (state == uart_msg_pkg::tx_stop_bit) && bit_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= uart_msg_pkg::tx_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_line  <= 1'b1;
        end else begin
            case (state)
                uart_msg_pkg::tx_idle: begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (tx_start) begin
                        tx_line <= 1'b0;
                        state   <= uart_msg_pkg::tx_start_bit;
                    end
                end

                uart_msg_pkg::tx_start_bit: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        tx_line  <= shift_reg[0];
                        state    <= uart_msg_pkg::tx_data_bit;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end

                uart_msg_pkg::tx_data_bit: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (bit_cnt == uart_cfg_pkg::data_bits - 1) begin
                            tx_line <= 1'b1;
                            state   <= uart_msg_pkg::tx_stop_bit;
                        end else begin
                            // next bit is the one about to shift into position 0
                            tx_line <= shift_reg[1];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end

                uart_msg_pkg::tx_stop_bit: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        state    <= uart_msg_pkg::tx_idle;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end

                default: begin
                    tx_line <= 1'b1;
                    state   <= uart_msg_pkg::tx_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= tx_data;
        end else if (state == uart_msg_pkg::tx_data_bit && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps
// 8N1 receiver without oversampling; rx_line may be asynchronous, start must hold to mid-bit
module uart_rx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rx_line,
    output uart_msg_pkg::rx_frame_t rx_frame,
    output logic                    rx_valid
);

    logic                                rx_meta;
    logic                                rx_sync;
    uart_msg_pkg::rx_state_e             state;
    logic [uart_cfg_pkg::cnt_w-1:0]      baud_cnt;
    logic [uart_cfg_pkg::bit_cnt_w-1:0]  bit_cnt;
    uart_cfg_pkg::data_t                 shift_reg;
    logic                                bit_end;
    logic                                start_mid;

    // one full bit period from the last sample point
    assign bit_end = (baud_cnt == uart_cfg_pkg::clks_per_bit - 1);
    // middle of the start bit, counted from the falling edge
    assign start_mid = (baud_cnt == uart_cfg_pkg::half_bit - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            state    <= uart_msg_pkg::rx_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx_line;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;

            case (state)
                uart_msg_pkg::rx_idle: begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (!rx_sync) begin
                        state <= uart_msg_pkg::rx_start_det;
                    end
                end

                uart_msg_pkg::rx_start_det: begin
                    if (start_mid) begin
                        baud_cnt <= '0;
                        // line back high means a glitch, not a start bit
                        if (rx_sync) begin
                            state <= uart_msg_pkg::rx_idle;
                        end else begin
                            state <= uart_msg_pkg::rx_receiving;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end

                uart_msg_pkg::rx_receiving: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (bit_cnt == uart_cfg_pkg::data_bits - 1) begin
                            state <= uart_msg_pkg::rx_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end

                uart_msg_pkg::rx_stop: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        rx_valid <= 1'b1;
                        state    <= uart_msg_pkg::rx_idle;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= uart_msg_pkg::rx_idle;
                end
            endcase
        end
    end

    // data arrives LSB first
    always_ff @(posedge clk) begin
        if (state == uart_msg_pkg::rx_receiving && bit_end) begin
            shift_reg <= {rx_sync, shift_reg[uart_cfg_pkg::data_bits-1:1]};
        end
    end

    // byte is kept even when the stop bit is low
    always_ff @(posedge clk) begin
        if (state == uart_msg_pkg::rx_stop && bit_end) begin
            rx_frame.data      <= shift_reg;
            rx_frame.frame_err <= ~rx_sync;
        end
    end

endmodule

// ==== source/uart_msg_pkg.sv ====
// message structs and FSM encodings shared by the UART blocks; no parity or break fields
package uart_msg_pkg;

    // byte just finished by the receiver
    typedef struct packed {
        uart_cfg_pkg::data_t data;
        logic                frame_err;
    } rx_frame_t;

    // message handed to the host
    typedef struct packed {
        uart_cfg_pkg::data_t data;
        logic                frame_err;
        logic                overrun;
    } rx_msg_t;

    typedef enum logic [1:0] {
        rx_idle      = 2'd0,
        rx_start_det = 2'd1,
        rx_receiving = 2'd2,
        rx_stop      = 2'd3
    } rx_state_e;

    typedef enum logic [1:0] {
        tx_idle      = 2'd0,
        tx_start_bit = 2'd1,
        tx_data_bit  = 2'd2,
        tx_stop_bit  = 2'd3
    } tx_state_e;

    // four-phase handshake progress
    typedef enum logic [1:0] {
        hs_idle     = 2'd0,
        hs_busy     = 2'd1,
        hs_ack_high = 2'd2,
        hs_wait_low = 2'd3
    } hs_state_e;

endpackage

// ==== source/uart_cfg_pkg.sv ====
// link constants for a fixed 8N1 frame; bit period is fixed at build time, no runtime baud
package uart_cfg_pkg;

    // clocks in one bit period
    localparam int clks_per_bit = 16;

    // mid-bit sample offset
    localparam int half_bit = clks_per_bit / 2;

    // data bits per frame, LSB first
    localparam int data_bits = 8;

    // counter widths derived from the above
    localparam int cnt_w = $clog2(clks_per_bit);
    localparam int bit_cnt_w = $clog2(data_bits);

    typedef logic [data_bits-1:0] data_t;

endpackage
